// ==== Makefile ====
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= bp_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides the verdict, not the exit status of the simulator
run: compile
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bp_bank.sv ====
`timescale 1ns/10ps
`include "bp_defs.svh"

module bp_bank import bp_pkg::*; (
	input  logic  clk_i,
	input  logic  rst_i,
	// Lookup port
	input  logic  look_en_i,
	input  row_t  look_row_i,
	input  tag_t  look_tag_i,
	// Resolve port
	input  logic  upd_en_i,
	input  row_t  upd_row_i,
	input  tag_t  upd_tag_i,
	input  logic  upd_taken_i,
	input  addr_t upd_target_i,
	// Lookup answer, zero when not enabled
	output logic  hit_o,
	output logic  taken_o,
	output addr_t target_o
);

	logic [`BP_ROWS-1:0] valid_q;
	tag_t                tag_q    [`BP_ROWS];
	bp_state_e           state_q  [`BP_ROWS];
	addr_t               target_q [`BP_ROWS];

	logic                upd_match;
	bp_state_e           upd_state;
	logic                look_match;

	// One step toward the outcome, saturating at both ends
	function automatic bp_state_e step_state(input bp_state_e cur, input logic taken);
		bp_state_e nxt;
		nxt = cur;
		case (cur)
			STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
			WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
			WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
			STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
			default:   nxt = STRONG_NT;
		endcase
		return nxt;
	endfunction

	// Resolve side, tag compare against the old entry
	assign upd_match = valid_q[upd_row_i] && (tag_q[upd_row_i] == upd_tag_i);
	assign upd_state = step_state(state_q[upd_row_i], upd_taken_i);

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			valid_q <= '0;
			for (int r = 0; r < `BP_ROWS; r++) begin
				state_q[r]  <= STRONG_NT;
				target_q[r] <= '0;
			end
		end else if (upd_en_i) begin
			if (upd_match) begin
				state_q[upd_row_i] <= upd_state;
				// Target refreshed only while heading taken
				if (upd_state[1] && upd_taken_i)
					target_q[upd_row_i] <= upd_target_i;
			end else begin
				// Claim the row for the new branch
				valid_q[upd_row_i] <= 1'b1;
				state_q[upd_row_i] <= STRONG_NT;
			end
		end
	end

	// Tags change only on a claim
	always_ff @(posedge clk_i) begin
		if (upd_en_i && !upd_match)
			tag_q[upd_row_i] <= upd_tag_i;
	end

	// Lookup is a pure read of the current contents
	assign look_match = valid_q[look_row_i] && (tag_q[look_row_i] == look_tag_i);

	always_comb begin
		hit_o    = 1'b0;
		taken_o  = 1'b0;
		target_o = '0;
		if (look_en_i) begin
			hit_o    = look_match;
			taken_o  = state_q[look_row_i][1];  // Upper bit predicts taken
			target_o = target_q[look_row_i];
		end
	end

endmodule

// ==== bp_checker.sv ====
`timescale 1ns/10ps
`include "bp_defs.svh"

module bp_checker import bp_pkg::*; (
	input logic                 clk_i,
	input logic                 rst_i,
	input logic                 lookup_i,
	input addr_t                pc_i,
	input logic                 pred_valid_i,
	input addr_t                next_pc_i,
	input logic [`BP_CNT_W-1:0] cnt_pred_t_i,
	input logic [`BP_CNT_W-1:0] cnt_pred_nt_i,
	input logic [`BP_CNT_W-1:0] cnt_res_t_i,
	input logic [`BP_CNT_W-1:0] cnt_res_nt_i
);

	int fail_cnt;

	initial fail_cnt = 0;

	a_idle_zero: assert property (@(posedge clk_i) disable iff (!rst_i)
		!lookup_i |-> (!pred_valid_i && next_pc_i == '0))
	else begin
		fail_cnt++;
		$error("prediction outputs not zero without a lookup");
	end

	a_miss_step: assert property (@(posedge clk_i) disable iff (!rst_i)
		(lookup_i && !pred_valid_i) |-> (next_pc_i == pc_i + 32'd4))
	else begin
		fail_cnt++;
		$error("lookup miss did not return pc plus 4");
	end

	// Counters only ever move up
	a_cnt_rise: assert property (@(posedge clk_i) disable iff (!rst_i)
		(cnt_pred_t_i >= $past(cnt_pred_t_i)) && (cnt_pred_nt_i >= $past(cnt_pred_nt_i)) &&
		(cnt_res_t_i >= $past(cnt_res_t_i)) && (cnt_res_nt_i >= $past(cnt_res_nt_i)))
	else begin
		fail_cnt++;
		$error("event counter decreased");
	end

endmodule

bind bp_top bp_checker u_checker (
	.clk_i         (clk_i),
	.rst_i         (rst_i),
	.lookup_i      (lookup_i),
	.pc_i          (pc_i),
	.pred_valid_i  (pred_valid_o),
	.next_pc_i     (next_pc_o),
	.cnt_pred_t_i  (cnt_pred_t_o),
	.cnt_pred_nt_i (cnt_pred_nt_o),
	.cnt_res_t_i   (cnt_res_t_o),
	.cnt_res_nt_i  (cnt_res_nt_o)
);

// ==== bp_collect.sv ====
`timescale 1ns/10ps
`include "bp_defs.svh"

module bp_collect import bp_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_i,
	// Current lookup
	input  logic                  lookup_i,
	input  addr_t                 pc_i,
	// Answers from all banks
	input  logic  [`BP_BANKS-1:0] hit_i,
	input  logic  [`BP_BANKS-1:0] taken_i,
	input  addr_t [`BP_BANKS-1:0] target_i,
	// Resolve strobe for the event counters
	input  logic                  upd_valid_i,
	input  logic                  upd_taken_i,
	// Prediction
	output logic                  pred_valid_o,
	output addr_t                 next_pc_o,
	// Event counters
	output logic  [`BP_CNT_W-1:0] cnt_pred_t_o,
	output logic  [`BP_CNT_W-1:0] cnt_pred_nt_o,
	output logic  [`BP_CNT_W-1:0] cnt_res_t_o,
	output logic  [`BP_CNT_W-1:0] cnt_res_nt_o
);

	logic  hit_any;
	logic  taken_any;
	addr_t target_any;
	logic  pred_taken;

	// Idle banks answer zero, so a plain OR merges them
	always_comb begin
		hit_any    = 1'b0;
		taken_any  = 1'b0;
		target_any = '0;
		for (int b = 0; b < `BP_BANKS; b++) begin
			hit_any    = hit_any | hit_i[b];
			taken_any  = taken_any | taken_i[b];
			target_any = target_any | target_i[b];
		end
	end

	assign pred_taken   = hit_any && taken_any;
	assign pred_valid_o = hit_any;

	always_comb begin
		if (pred_taken)
			next_pc_o = target_any;
		else if (lookup_i)
			next_pc_o = pc_i + addr_t'(`BP_PC_STEP);  // Fall through
		else
			next_pc_o = '0;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			cnt_pred_t_o  <= '0;
			cnt_pred_nt_o <= '0;
			cnt_res_t_o   <= '0;
			cnt_res_nt_o  <= '0;
		end else begin
			// Misses count as predicted not taken
			if (lookup_i && pred_taken)
				cnt_pred_t_o <= cnt_pred_t_o + 1'b1;
			if (lookup_i && !pred_taken)
				cnt_pred_nt_o <= cnt_pred_nt_o + 1'b1;
			if (upd_valid_i && upd_taken_i)
				cnt_res_t_o <= cnt_res_t_o + 1'b1;
			if (upd_valid_i && !upd_taken_i)
				cnt_res_nt_o <= cnt_res_nt_o + 1'b1;
		end
	end

endmodule

// ==== bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Address and counter widths
`define BP_ADDR_W 32
`define BP_CNT_W 32

// Table geometry
`define BP_BANKS 4
`define BP_BANK_W 2
`define BP_ROWS 32
`define BP_ROW_W 5
`define BP_TAG_W 23

// Field positions inside a program counter
`define BP_BANK_LSB 2   // Bits 3..2 pick the bank
`define BP_ROW_LSB 4    // Bits 8..4 pick the row
`define BP_TAG_LSB 9    // Bits 31..9 form the tag

// Fetch step for a not-taken prediction
`define BP_PC_STEP 4

`endif

// ==== bp_dispatch.sv ====
`timescale 1ns/10ps
`include "bp_defs.svh"

module bp_dispatch import bp_pkg::*; (
	// Lookup side
	input  logic                 lookup_i,
	input  addr_t                pc_i,
	// Resolve side
	input  logic                 upd_valid_i,
	input  addr_t                upd_pc_i,
	// Per-bank lookup strobes and shared fields
	output logic [`BP_BANKS-1:0] look_en_o,
	output row_t                 look_row_o,
	output tag_t                 look_tag_o,
	// Per-bank resolve strobes and shared fields
	output logic [`BP_BANKS-1:0] upd_en_o,
	output row_t                 upd_row_o,
	output tag_t                 upd_tag_o
);

	logic [`BP_BANK_W-1:0] look_bank;
	logic [`BP_BANK_W-1:0] upd_bank;

	// Bank select fields
	assign look_bank = pc_i[`BP_BANK_LSB +: `BP_BANK_W];
	assign upd_bank  = upd_pc_i[`BP_BANK_LSB +: `BP_BANK_W];

	// Lookup decode, all zero without a request
	always_comb begin
		look_en_o  = '0;
		look_row_o = '0;
		look_tag_o = '0;
		if (lookup_i) begin
			look_en_o[look_bank] = 1'b1;
			look_row_o = pc_i[`BP_ROW_LSB +: `BP_ROW_W];
			look_tag_o = pc_i[`BP_TAG_LSB +: `BP_TAG_W];
		end
	end

	// Resolve decode follows the same rules
	always_comb begin
		upd_en_o  = '0;
		upd_row_o = '0;
		upd_tag_o = '0;
		if (upd_valid_i) begin
			upd_en_o[upd_bank] = 1'b1;   // Only the owning bank trains
			upd_row_o = upd_pc_i[`BP_ROW_LSB +: `BP_ROW_W];
			upd_tag_o = upd_pc_i[`BP_TAG_LSB +: `BP_TAG_W];
		end
	end

endmodule

// ==== bp_pkg.sv ====
`include "bp_defs.svh"

package bp_pkg;

	// Two-bit saturating counter, upper bit predicts taken
	typedef enum logic [1:0] {
		STRONG_NT = 2'd0,
		WEAK_NT   = 2'd1,
		WEAK_T    = 2'd2,
		STRONG_T  = 2'd3
	} bp_state_e;

	typedef logic [`BP_ADDR_W-1:0] addr_t;  // Program counter or target
	typedef logic [`BP_TAG_W-1:0]  tag_t;
	typedef logic [`BP_ROW_W-1:0]  row_t;

endpackage

// ==== bp_tb.sv ====
`timescale 1ns/10ps
`include "bp_defs.svh"

module bp_tb import bp_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int TBL_ROWS   = 29;
	localparam int RAND_STEPS = 200;
	localparam int TIMEOUT_NS = (TBL_ROWS + RAND_STEPS + 20) * CLK_PERIOD;

	localparam logic  Y   = 1'b1;
	localparam logic  N   = 1'b0;
	localparam addr_t Z   = '0;
	localparam addr_t A   = 32'h0000_1230;  // Bank 0, row 3, tag 9
	localparam addr_t B   = 32'h0000_1430;  // Bank 0, row 3, tag 10
	localparam addr_t C   = 32'h0000_1234;  // Bank 1, row 3, tag 9
	localparam addr_t TA  = 32'h0000_8000;
	localparam addr_t TA2 = 32'h0000_8800;
	localparam addr_t TB  = 32'h0000_A000;
	localparam addr_t TC  = 32'h0000_9000;

	typedef struct packed {
		logic  look;
		addr_t pc;
		logic  res;
		addr_t rpc;
		logic  taken;
		addr_t target;
		logic  exp_valid;
		addr_t exp_next;
	} step_t;

	logic                 clk;
	logic                 rst;
	logic                 lookup;
	addr_t                pc;
	logic                 upd_valid;
	logic                 upd_taken;
	addr_t                upd_pc;
	addr_t                upd_target;
	logic                 pred_valid;
	addr_t                next_pc;
	logic [`BP_CNT_W-1:0] cnt_pred_t;
	logic [`BP_CNT_W-1:0] cnt_pred_nt;
	logic [`BP_CNT_W-1:0] cnt_res_t;
	logic [`BP_CNT_W-1:0] cnt_res_nt;

	// Reference table model, state kept as 0..3
	logic                 m_valid  [`BP_BANKS][`BP_ROWS];
	tag_t                 m_tag    [`BP_BANKS][`BP_ROWS];
	int                   m_state  [`BP_BANKS][`BP_ROWS];
	addr_t                m_target [`BP_BANKS][`BP_ROWS];
	logic [`BP_CNT_W-1:0] n_pred_t;
	logic [`BP_CNT_W-1:0] n_pred_nt;
	logic [`BP_CNT_W-1:0] n_res_t;
	logic [`BP_CNT_W-1:0] n_res_nt;

	int          n_checks;
	int          n_errors;
	logic [15:0] lfsr_q;
	step_t       tbl_q [$];

	bp_top uut (
		.clk_i         (clk),
		.rst_i         (rst),
		.lookup_i      (lookup),
		.pc_i          (pc),
		.upd_valid_i   (upd_valid),
		.upd_taken_i   (upd_taken),
		.upd_pc_i      (upd_pc),
		.upd_target_i  (upd_target),
		.pred_valid_o  (pred_valid),
		.next_pc_o     (next_pc),
		.cnt_pred_t_o  (cnt_pred_t),
		.cnt_pred_nt_o (cnt_pred_nt),
		.cnt_res_t_o   (cnt_res_t),
		.cnt_res_nt_o  (cnt_res_nt)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	task automatic check_bit(input string what, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input addr_t got, input addr_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cnt(input string what, input logic [`BP_CNT_W-1:0] got,
			input logic [`BP_CNT_W-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (n_errors == err_before)
			$display("test %s: ok", name);
		else
			$display("test %s: failed", name);
	endtask

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (b)
			lfsr_q = lfsr_q ^ 16'hB400;
		return b;
	endfunction

	function automatic addr_t rand_bits(input int n);
		addr_t v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[`BP_ADDR_W-2:0], lfsr_bit()};
		return v;
	endfunction

	// Small address pool so rows get reused and evicted
	function automatic addr_t make_pc();
		addr_t tag_part;
		addr_t row_part;
		addr_t bank_part;
		tag_part  = rand_bits(2) << 9;
		row_part  = rand_bits(2) << 4;
		bank_part = rand_bits(2) << 2;
		return 32'h0040_0000 | tag_part | row_part | bank_part;
	endfunction

	function automatic step_t random_step();
		step_t s;
		s        = '0;
		s.look   = rand_bits(1) != '0;
		s.pc     = make_pc();
		s.res    = rand_bits(1) != '0;
		s.rpc    = make_pc();
		s.taken  = rand_bits(2) != '0;  // Leans taken
		s.target = 32'h0010_0000 | (rand_bits(8) << 2);
		return s;
	endfunction

	function automatic void model_reset();
		for (int b = 0; b < `BP_BANKS; b++) begin
			for (int r = 0; r < `BP_ROWS; r++) begin
				m_valid[b][r]  = 1'b0;
				m_tag[b][r]    = '0;
				m_state[b][r]  = 0;
				m_target[b][r] = '0;
			end
		end
		n_pred_t  = '0;
		n_pred_nt = '0;
		n_res_t   = '0;
		n_res_nt  = '0;
	endfunction

	task automatic model_predict(input addr_t a, input logic look, output logic v,
			output logic tk, output addr_t nxt);
		logic [`BP_BANK_W-1:0] b;
		row_t                  r;
		tag_t                  t;
		b   = a[`BP_BANK_LSB +: `BP_BANK_W];
		r   = a[`BP_ROW_LSB +: `BP_ROW_W];
		t   = a[`BP_TAG_LSB +: `BP_TAG_W];
		v   = look && m_valid[b][r] && (m_tag[b][r] == t);
		tk  = v && (m_state[b][r] >= 2);
		nxt = !look ? Z : (tk ? m_target[b][r] : a + 32'd4);
	endtask

	task automatic model_resolve(input addr_t a, input logic tk, input addr_t tgt);
		logic [`BP_BANK_W-1:0] b;
		row_t                  r;
		tag_t                  t;
		b = a[`BP_BANK_LSB +: `BP_BANK_W];
		r = a[`BP_ROW_LSB +: `BP_ROW_W];
		t = a[`BP_TAG_LSB +: `BP_TAG_W];
		if (m_valid[b][r] && m_tag[b][r] == t) begin
			if (tk && m_state[b][r] < 3)
				m_state[b][r] = m_state[b][r] + 1;
			else if (!tk && m_state[b][r] > 0)
				m_state[b][r] = m_state[b][r] - 1;
			if (tk && m_state[b][r] >= 2)
				m_target[b][r] = tgt;
		end else begin
			m_valid[b][r] = 1'b1;  // Claim, old target stays
			m_tag[b][r]   = t;
			m_state[b][r] = 0;
		end
		if (tk)
			n_res_t++;
		else
			n_res_nt++;
	endtask

	task automatic add_row(input logic look, input addr_t a, input logic res, input addr_t ra,
			input logic tk, input addr_t tgt, input logic ev, input addr_t en);
		step_t s;
		s = {look, a, res, ra, tk, tgt, ev, en};
		tbl_q.push_back(s);
	endtask

	task automatic build_table();
		add_row(Y, A, N, Z, N, Z,   N, A + 4);  // Cold misses
		add_row(Y, C, N, Z, N, Z,   N, C + 4);
		add_row(N, Z, N, Z, N, Z,   N, Z);      // Idle lookup
		add_row(N, Z, Y, A, Y, TA,  N, Z);      // Claim as STRONG_NT
		add_row(Y, A, Y, A, Y, TA,  Y, A + 4);
		add_row(Y, A, Y, A, Y, TA,  Y, A + 4);
		add_row(Y, A, Y, A, Y, TA,  Y, TA);     // WEAK_T hit
		add_row(Y, A, Y, A, Y, TA,  Y, TA);
		add_row(Y, A, N, Z, N, Z,   Y, TA);     // Saturated at STRONG_T
		add_row(N, Z, Y, A, N, Z,   N, Z);
		add_row(Y, A, N, Z, N, Z,   Y, TA);
		add_row(Y, A, Y, A, N, Z,   Y, TA);
		add_row(Y, A, N, Z, N, Z,   Y, A + 4);  // Back in the not-taken half
		add_row(Y, A, Y, A, N, Z,   Y, A + 4);
		add_row(Y, A, Y, A, N, Z,   Y, A + 4);
		add_row(Y, A, Y, C, Y, TC,  Y, A + 4);  // Bank 1 trains alone
		add_row(Y, C, Y, C, Y, TC,  Y, C + 4);
		add_row(Y, C, Y, C, Y, TC,  Y, C + 4);
		add_row(Y, C, N, Z, N, Z,   Y, TC);
		add_row(Y, A, Y, B, Y, TB,  Y, A + 4);  // Other tag evicts A
		add_row(Y, A, N, Z, N, Z,   N, A + 4);
		add_row(Y, B, N, Z, N, Z,   Y, B + 4);
		add_row(Y, B, Y, A, Y, TA,  Y, B + 4);
		add_row(Y, B, N, Z, N, Z,   N, B + 4);
		add_row(Y, A, N, Z, N, Z,   Y, A + 4);  // Restarted at STRONG_NT
		add_row(Y, C, N, Z, N, Z,   Y, TC);
		add_row(Y, A, Y, A, Y, TA2, Y, A + 4);  // Old entry in the resolve cycle
		add_row(Y, A, Y, A, Y, TA2, Y, A + 4);
		add_row(Y, A, N, Z, N, Z,   Y, TA2);
	endtask

	// Drive on the falling edge, check halfway to the rising edge
	task automatic apply_step(input step_t s, input logic from_model);
		logic  ev;
		logic  etk;
		addr_t en;
		@(negedge clk);
		lookup     = s.look;
		pc         = s.pc;
		upd_valid  = s.res;
		upd_pc     = s.rpc;
		upd_taken  = s.taken;
		upd_target = s.target;
		model_predict(s.pc, s.look, ev, etk, en);
		if (!from_model) begin
			ev = s.exp_valid;
			en = s.exp_next;
		end
		#(CLK_PERIOD/4);
		check_bit("pred_valid", pred_valid, ev);
		check_addr("next_pc", next_pc, en);
		if (s.look && etk)
			n_pred_t++;
		else if (s.look)
			n_pred_nt++;
		if (s.res)
			model_resolve(s.rpc, s.taken, s.target);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int e0;
		rst        = 1'b0;
		lookup     = 1'b0;
		pc         = '0;
		upd_valid  = 1'b0;
		upd_taken  = 1'b0;
		upd_pc     = '0;
		upd_target = '0;
		lfsr_q     = 16'd2225;
		n_checks   = 0;
		n_errors   = 0;
		model_reset();
		build_table();

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		#(CLK_PERIOD/4);
		e0 = n_errors;
		check_cnt("cnt_pred_t", cnt_pred_t, '0);
		check_cnt("cnt_pred_nt", cnt_pred_nt, '0);
		check_cnt("cnt_res_t", cnt_res_t, '0);
		check_cnt("cnt_res_nt", cnt_res_nt, '0);
		report_test("reset", e0);

		foreach (tbl_q[i]) begin
			e0 = n_errors;
			apply_step(tbl_q[i], 1'b0);
			report_test($sformatf("row %0d", i), e0);
		end

		e0 = n_errors;
		for (int i = 0; i < RAND_STEPS; i++)
			apply_step(random_step(), 1'b1);
		report_test("random", e0);

		// Let the last step's edge land before reading the counters
		@(negedge clk);
		lookup    = 1'b0;
		upd_valid = 1'b0;
		#(CLK_PERIOD/4);
		e0 = n_errors;
		check_cnt("cnt_pred_t", cnt_pred_t, n_pred_t);
		check_cnt("cnt_pred_nt", cnt_pred_nt, n_pred_nt);
		check_cnt("cnt_res_t", cnt_res_t, n_res_t);
		check_cnt("cnt_res_nt", cnt_res_nt, n_res_nt);
		report_test("counters", e0);

		if (uut.u_checker.fail_cnt != 0) begin
			n_errors++;
			$display("The bound checker saw %0d assertion failures", uut.u_checker.fail_cnt);
		end

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== bp_top.sv ====
`timescale 1ns/10ps
`include "bp_defs.svh"

module bp_top import bp_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,
	// Fetch lookup
	input  logic                 lookup_i,
	input  addr_t                pc_i,
	// Resolved branch
	input  logic                 upd_valid_i,
	input  logic                 upd_taken_i,
	input  addr_t                upd_pc_i,
	input  addr_t                upd_target_i,
	// Prediction
	output logic                 pred_valid_o,
	output addr_t                next_pc_o,
	// Event counters
	output logic [`BP_CNT_W-1:0] cnt_pred_t_o,
	output logic [`BP_CNT_W-1:0] cnt_pred_nt_o,
	output logic [`BP_CNT_W-1:0] cnt_res_t_o,
	output logic [`BP_CNT_W-1:0] cnt_res_nt_o
);

	logic  [`BP_BANKS-1:0] look_en;
	logic  [`BP_BANKS-1:0] upd_en;
	row_t                  look_row;
	tag_t                  look_tag;
	row_t                  upd_row;
	tag_t                  upd_tag;

	logic  [`BP_BANKS-1:0] bank_hit;
	logic  [`BP_BANKS-1:0] bank_taken;
	addr_t [`BP_BANKS-1:0] bank_target;

	bp_dispatch u_dispatch (
		.lookup_i    (lookup_i),
		.pc_i        (pc_i),
		.upd_valid_i (upd_valid_i),
		.upd_pc_i    (upd_pc_i),
		.look_en_o   (look_en),
		.look_row_o  (look_row),
		.look_tag_o  (look_tag),
		.upd_en_o    (upd_en),
		.upd_row_o   (upd_row),
		.upd_tag_o   (upd_tag)
	);

	// Banks share row and tag, only the strobes differ
	for (genvar g = 0; g < `BP_BANKS; g++) begin : g_bank
		bp_bank u_bank (
			.clk_i        (clk_i),
			.rst_i        (rst_i),
			.look_en_i    (look_en[g]),
			.look_row_i   (look_row),
			.look_tag_i   (look_tag),
			.upd_en_i     (upd_en[g]),
			.upd_row_i    (upd_row),
			.upd_tag_i    (upd_tag),
			.upd_taken_i  (upd_taken_i),
			.upd_target_i (upd_target_i),
			.hit_o        (bank_hit[g]),
			.taken_o      (bank_taken[g]),
			.target_o     (bank_target[g])
		);
	end

	bp_collect u_collect (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.lookup_i      (lookup_i),
		.pc_i          (pc_i),
		.hit_i         (bank_hit),
		.taken_i       (bank_taken),
		.target_i      (bank_target),
		.upd_valid_i   (upd_valid_i),
		.upd_taken_i   (upd_taken_i),
		.pred_valid_o  (pred_valid_o),
		.next_pc_o     (next_pc_o),
		.cnt_pred_t_o  (cnt_pred_t_o),
		.cnt_pred_nt_o (cnt_pred_nt_o),
		.cnt_res_t_o   (cnt_res_t_o),
		.cnt_res_nt_o  (cnt_res_nt_o)
	);

endmodule

// ==== build.f ====
+incdir+.
bp_pkg.sv
bp_dispatch.sv
bp_bank.sv
bp_collect.sv
bp_top.sv
bp_checker.sv
bp_tb.sv
